//--- src/risc_pkg.sv
// Shared widths, instruction encodings and bundle types, referenced by scoped names in the core
package risc_pkg;

  localparam int XLEN        = 32;
  localparam int REG_COUNT   = 16;
  localparam int REG_IDX_W   = 4;     // Top bit of the 5-bit fields ignored
  localparam int IMEM_DEPTH  = 64;
  localparam int IMEM_ADDR_W = 6;     // Fetch index is pc[7:2]
  localparam int DMEM_DEPTH  = 1024;
  localparam int DMEM_ADDR_W = 10;    // Low bits of the computed address

  localparam logic [XLEN-1:0] HALT_WORD = 32'hFFFF_FFFF;

  // Instruction class in bits 31:30
  localparam logic [1:0] CLASS_R = 2'b00;
  localparam logic [1:0] CLASS_I = 2'b01;
  localparam logic [1:0] CLASS_M = 2'b10;
  localparam logic [1:0] CLASS_B = 2'b11;

  localparam logic [5:0] OP_R    = 6'h00;
  localparam logic [5:0] OP_ADDI = 6'h10;
  localparam logic [5:0] OP_SUBI = 6'h11;
  localparam logic [5:0] OP_ANDI = 6'h12;
  localparam logic [5:0] OP_ORI  = 6'h13;
  localparam logic [5:0] OP_XORI = 6'h14;
  localparam logic [5:0] OP_NOTI = 6'h15;
  localparam logic [5:0] OP_SLAI = 6'h16;
  localparam logic [5:0] OP_SLLI = 6'h17;
  localparam logic [5:0] OP_SRAI = 6'h18;
  localparam logic [5:0] OP_SRLI = 6'h19;
  localparam logic [5:0] OP_MOVE = 6'h1A;
  localparam logic [5:0] OP_LD   = 6'h21;
  localparam logic [5:0] OP_ST   = 6'h22;
  localparam logic [5:0] OP_BR   = 6'h30;
  localparam logic [5:0] OP_BMI  = 6'h31;
  localparam logic [5:0] OP_BPL  = 6'h32;
  localparam logic [5:0] OP_BZ   = 6'h33;

  // R-type function field, bits 5:0
  localparam logic [5:0] FN_ADD = 6'd1;
  localparam logic [5:0] FN_SUB = 6'd2;
  localparam logic [5:0] FN_AND = 6'd3;
  localparam logic [5:0] FN_OR  = 6'd4;
  localparam logic [5:0] FN_XOR = 6'd5;
  localparam logic [5:0] FN_NOT = 6'd6;
  localparam logic [5:0] FN_SLA = 6'd7;
  localparam logic [5:0] FN_SLL = 6'd8;
  localparam logic [5:0] FN_SRA = 6'd9;
  localparam logic [5:0] FN_SRL = 6'd10;

  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_AND  = 4'd2;
  localparam logic [3:0] ALU_XOR  = 4'd3;
  localparam logic [3:0] ALU_OR   = 4'd4;
  localparam logic [3:0] ALU_NOT  = 4'd5;
  localparam logic [3:0] ALU_SLA  = 4'd6;
  localparam logic [3:0] ALU_SLL  = 4'd7;
  localparam logic [3:0] ALU_SRA  = 4'd8;
  localparam logic [3:0] ALU_SRL  = 4'd9;
  localparam logic [3:0] ALU_BTGT = 4'd10;   // a + b*4

  localparam logic [1:0] COND_ALWAYS = 2'd0;
  localparam logic [1:0] COND_NEG    = 2'd1;
  localparam logic [1:0] COND_POS    = 2'd2;
  localparam logic [1:0] COND_ZERO   = 2'd3;

  // Sequencer states
  localparam logic [2:0] S_HALT = 3'd0;
  localparam logic [2:0] S_IF   = 3'd1;
  localparam logic [2:0] S_ID   = 3'd2;
  localparam logic [2:0] S_EX   = 3'd3;
  localparam logic [2:0] S_MEM  = 3'd4;
  localparam logic [2:0] S_WB   = 3'd5;

  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] unused;
      logic [5:0] func;
    } r;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;   // Immediate, memory offset or branch word offset
    } i;
    logic [XLEN-1:0] word;
  } instr_t;

  typedef struct packed {
    logic       ld_ir;
    logic       ld_ab;
    logic       ld_aluout;
    logic       ld_lmd;
    logic       ld_pc;
    logic       sel_a_pc;
    logic       sel_b_imm;
    logic       sel_dest_rt;
    logic       sel_wb_mem;
    logic [3:0] alu_op;
    logic [1:0] cond;
    logic       is_branch;
    logic       reg_write;
    logic       mem_write;
  } ctrl_t;

  typedef struct packed {
    logic                   wb_valid;
    logic [REG_IDX_W-1:0]   wb_reg;
    logic [XLEN-1:0]        wb_data;
    logic                   st_valid;
    logic [DMEM_ADDR_W-1:0] st_addr;
    logic [XLEN-1:0]        st_data;
  } trace_t;

endpackage

//--- src/alu.sv
// Combinational ALU for arithmetic, logic, single-bit shifts and the branch-target add
module alu (
  input  logic signed [risc_pkg::XLEN-1:0] a,
  input  logic signed [risc_pkg::XLEN-1:0] b,
  input  logic [3:0]                       op,
  output logic [risc_pkg::XLEN-1:0]        result
);

  always_comb
  begin
    case (op)
      risc_pkg::ALU_ADD:  result = a + b;
      risc_pkg::ALU_SUB:  result = a - b;
      risc_pkg::ALU_AND:  result = a & b;
      risc_pkg::ALU_XOR:  result = a ^ b;
      risc_pkg::ALU_OR:   result = a | b;
      risc_pkg::ALU_NOT:  result = ~a;          // b ignored

      // Shift amount is b[0] only
      risc_pkg::ALU_SLA,
      risc_pkg::ALU_SLL:  result = a << b[0];
      risc_pkg::ALU_SRA:  result = a >>> b[0];  // Sign fills from a
      risc_pkg::ALU_SRL:  result = a >> b[0];

      // Word offset scaled to bytes
      risc_pkg::ALU_BTGT: result = a + {b[risc_pkg::XLEN-3:0], 2'b00};
      default:            result = a;
    endcase
  end

endmodule

//--- src/branch_cond.sv
// Compares a register value with zero to decide whether a branch is taken
module branch_cond (
  input  logic [risc_pkg::XLEN-1:0] value,
  input  logic [1:0]                cond,
  output logic                      taken
);

  always_comb
  begin
    case (cond)
      risc_pkg::COND_NEG:  taken = ($signed(value) < 0);
      risc_pkg::COND_POS:  taken = ($signed(value) > 0);
      risc_pkg::COND_ZERO: taken = (value == '0);
      default:             taken = 1'b1;   // Unconditional BR
    endcase
  end

endmodule

//--- src/reg_file.sv
// Sixteen-entry register bank with two read ports, one write port and r0 tied to zero
module reg_file (
  input  logic                           clk,
  input  logic [risc_pkg::REG_IDX_W-1:0] rs_idx,
  input  logic [risc_pkg::REG_IDX_W-1:0] rt_idx,
  input  logic [risc_pkg::REG_IDX_W-1:0] wr_idx,
  input  logic                           wr_en,
  input  logic [risc_pkg::XLEN-1:0]      wr_data,
  output logic [risc_pkg::XLEN-1:0]      rs_data,
  output logic [risc_pkg::XLEN-1:0]      rt_data
);

  logic [risc_pkg::XLEN-1:0] regs [risc_pkg::REG_COUNT];

  always_ff @(posedge clk)
  begin
    if (wr_en && wr_idx != '0)
      regs[wr_idx] <= wr_data;     // Lands at the WB edge
  end

  // r0 reads zero whatever the array holds
  assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
  assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

//--- src/instr_mem.sv
// Instruction memory, loaded through an external write port and read at the fetch index
module instr_mem (
  input  logic                             clk,
  input  logic                             we,
  input  logic [risc_pkg::IMEM_ADDR_W-1:0] waddr,
  input  logic [risc_pkg::XLEN-1:0]        wdata,
  input  logic [risc_pkg::IMEM_ADDR_W-1:0] raddr,
  output logic [risc_pkg::XLEN-1:0]        rdata
);

  logic [risc_pkg::XLEN-1:0] mem [risc_pkg::IMEM_DEPTH];

  always_ff @(posedge clk)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

  assign rdata = mem[raddr];   // Combinational fetch

endmodule

//--- src/data_mem.sv
// Word-addressed data memory with synchronous write and combinational read
module data_mem (
  input  logic                             clk,
  input  logic                             we,
  input  logic [risc_pkg::DMEM_ADDR_W-1:0] addr,
  input  logic [risc_pkg::XLEN-1:0]        wdata,
  output logic [risc_pkg::XLEN-1:0]        rdata
);

  logic [risc_pkg::XLEN-1:0] mem [risc_pkg::DMEM_DEPTH];

  always_ff @(posedge clk)
  begin
    if (we)
      mem[addr] <= wdata;      // Store in MEM cycle
  end

  assign rdata = mem[addr];

endmodule

//--- src/control_fsm.sv
// Five-state instruction sequencer with a halt state, decoding the latched instruction
module control_fsm (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  risc_pkg::instr_t          ir,
  input  logic [risc_pkg::XLEN-1:0] fetch_word,
  output risc_pkg::ctrl_t           ctrl,
  output logic                      halted
);

  logic [2:0] state;
  logic [2:0] state_nxt;
  logic [3:0] dec_alu_op;
  logic [1:0] dec_cond;
  logic       dec_a_pc;
  logic       dec_b_imm;
  logic       dec_dest_rt;
  logic       dec_load;
  logic       dec_store;
  logic       dec_branch;
  logic       dec_reg_wr;

  always_comb
  begin
    state_nxt = state;
    case (state)
      risc_pkg::S_HALT: if (start) state_nxt = risc_pkg::S_IF;   // Start ignored elsewhere
      risc_pkg::S_IF:
        state_nxt = (fetch_word == risc_pkg::HALT_WORD) ? risc_pkg::S_HALT : risc_pkg::S_ID;
      risc_pkg::S_ID:  state_nxt = risc_pkg::S_EX;
      risc_pkg::S_EX:  state_nxt = risc_pkg::S_MEM;
      risc_pkg::S_MEM: state_nxt = risc_pkg::S_WB;
      risc_pkg::S_WB:  state_nxt = risc_pkg::S_IF;
      default:         state_nxt = risc_pkg::S_HALT;
    endcase
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
      state <= risc_pkg::S_HALT;
    else
      state <= state_nxt;
  end

  assign halted = (state == risc_pkg::S_HALT);

  // Instruction decode, held steady from ID through WB
  always_comb
  begin
    dec_alu_op  = risc_pkg::ALU_ADD;
    dec_cond    = risc_pkg::COND_ALWAYS;
    dec_a_pc    = 1'b0;
    dec_b_imm   = 1'b0;
    dec_dest_rt = 1'b0;
    dec_load    = 1'b0;
    dec_store   = 1'b0;
    dec_branch  = 1'b0;
    dec_reg_wr  = 1'b0;
    case (ir.i.opcode[5:4])
      risc_pkg::CLASS_R:
      begin
        dec_reg_wr = 1'b1;
        case (ir.r.func)
          risc_pkg::FN_SUB: dec_alu_op = risc_pkg::ALU_SUB;
          risc_pkg::FN_AND: dec_alu_op = risc_pkg::ALU_AND;
          risc_pkg::FN_OR:  dec_alu_op = risc_pkg::ALU_OR;
          risc_pkg::FN_XOR: dec_alu_op = risc_pkg::ALU_XOR;
          risc_pkg::FN_NOT: dec_alu_op = risc_pkg::ALU_NOT;
          risc_pkg::FN_SLA: dec_alu_op = risc_pkg::ALU_SLA;
          risc_pkg::FN_SLL: dec_alu_op = risc_pkg::ALU_SLL;
          risc_pkg::FN_SRA: dec_alu_op = risc_pkg::ALU_SRA;
          risc_pkg::FN_SRL: dec_alu_op = risc_pkg::ALU_SRL;
          default:          dec_alu_op = risc_pkg::ALU_ADD;   // FN_ADD
        endcase
      end
      risc_pkg::CLASS_I:
      begin
        dec_b_imm   = 1'b1;
        dec_dest_rt = 1'b1;
        dec_reg_wr  = 1'b1;
        case (ir.i.opcode)
          risc_pkg::OP_SUBI: dec_alu_op = risc_pkg::ALU_SUB;
          risc_pkg::OP_ANDI: dec_alu_op = risc_pkg::ALU_AND;
          risc_pkg::OP_ORI:  dec_alu_op = risc_pkg::ALU_OR;
          risc_pkg::OP_XORI: dec_alu_op = risc_pkg::ALU_XOR;
          risc_pkg::OP_NOTI: dec_alu_op = risc_pkg::ALU_NOT;
          risc_pkg::OP_SLAI: dec_alu_op = risc_pkg::ALU_SLA;
          risc_pkg::OP_SLLI: dec_alu_op = risc_pkg::ALU_SLL;
          risc_pkg::OP_SRAI: dec_alu_op = risc_pkg::ALU_SRA;
          risc_pkg::OP_SRLI: dec_alu_op = risc_pkg::ALU_SRL;
          default:           dec_alu_op = risc_pkg::ALU_ADD;   // ADDI and MOVE (rs + imm16)
        endcase
      end
      risc_pkg::CLASS_M:
      begin
        dec_b_imm   = 1'b1;                                   // Address is rs + imm16
        dec_load    = (ir.i.opcode == risc_pkg::OP_LD);
        dec_store   = (ir.i.opcode == risc_pkg::OP_ST);
        dec_dest_rt = dec_load;
        dec_reg_wr  = dec_load;
      end
      default:
      begin
        dec_a_pc   = 1'b1;                                    // Target from PC+4 and offset
        dec_b_imm  = 1'b1;
        dec_alu_op = risc_pkg::ALU_BTGT;
        dec_branch = 1'b1;
        case (ir.i.opcode)
          risc_pkg::OP_BR:  dec_cond = risc_pkg::COND_ALWAYS;
          risc_pkg::OP_BMI: dec_cond = risc_pkg::COND_NEG;
          risc_pkg::OP_BPL: dec_cond = risc_pkg::COND_POS;
          risc_pkg::OP_BZ:  dec_cond = risc_pkg::COND_ZERO;
          default:          dec_branch = 1'b0;                // Unknown branch falls through
        endcase
      end
    endcase
  end

  // Control word is all zero only in HALT; the datapath relies on that for restart
  always_comb
  begin
    ctrl = '0;
    if (state != risc_pkg::S_HALT && state != risc_pkg::S_IF)
    begin
      ctrl.alu_op      = dec_alu_op;
      ctrl.cond        = dec_cond;
      ctrl.sel_a_pc    = dec_a_pc;
      ctrl.sel_b_imm   = dec_b_imm;
      ctrl.sel_dest_rt = dec_dest_rt;
      ctrl.sel_wb_mem  = dec_load;
      ctrl.is_branch   = dec_branch;
    end
    case (state)
      risc_pkg::S_IF:  ctrl.ld_ir     = 1'b1;
      risc_pkg::S_ID:  ctrl.ld_ab     = 1'b1;
      risc_pkg::S_EX:  ctrl.ld_aluout = 1'b1;
      risc_pkg::S_MEM:
      begin
        ctrl.ld_pc     = 1'b1;
        ctrl.ld_lmd    = dec_load;
        ctrl.mem_write = dec_store;
      end
      risc_pkg::S_WB:  ctrl.reg_write = dec_reg_wr;
      default:         ctrl.ld_ir     = 1'b0;
    endcase
  end

endmodule

//--- src/datapath.sv
// Datapath of the core: PC, pipeline latches, operand muxes, memories and the trace outputs
module datapath (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start,
  input  risc_pkg::ctrl_t                  ctrl,
  input  logic                             imem_we,
  input  logic [risc_pkg::IMEM_ADDR_W-1:0] imem_addr,
  input  logic [risc_pkg::XLEN-1:0]        imem_wdata,
  output risc_pkg::instr_t                 ir,
  output logic [risc_pkg::XLEN-1:0]        fetch_word,
  output risc_pkg::trace_t                 trace
);

  logic [risc_pkg::XLEN-1:0]      pc;
  logic [risc_pkg::XLEN-1:0]      npc;          // PC+4 of the current instruction
  logic [risc_pkg::XLEN-1:0]      a_reg;
  logic [risc_pkg::XLEN-1:0]      b_reg;
  logic [risc_pkg::XLEN-1:0]      imm_reg;
  logic [risc_pkg::XLEN-1:0]      alu_out;
  logic [risc_pkg::XLEN-1:0]      lmd;
  logic [risc_pkg::XLEN-1:0]      rs_data;
  logic [risc_pkg::XLEN-1:0]      rt_data;
  logic [risc_pkg::XLEN-1:0]      alu_a;
  logic [risc_pkg::XLEN-1:0]      alu_b;
  logic [risc_pkg::XLEN-1:0]      alu_result;
  logic [risc_pkg::XLEN-1:0]      dmem_rdata;
  logic [risc_pkg::XLEN-1:0]      wb_data;
  logic [risc_pkg::XLEN-1:0]      pc_next;
  logic [risc_pkg::REG_IDX_W-1:0] wr_idx;
  logic                           taken;
  logic                           seq_idle;

  assign seq_idle = (ctrl == '0);                // Sequencer sits in HALT
  assign pc_next  = (ctrl.is_branch && taken) ? alu_out : npc;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
      pc <= '0;
    else if (start && seq_idle)
      pc <= '0;                                  // Rerun from address 0
    else if (ctrl.ld_pc)
      pc <= pc_next;
  end

  always_ff @(posedge clk)
  begin
    if (ctrl.ld_ir)
    begin
      ir.word <= fetch_word;
      npc     <= pc + 32'd4;
    end
    if (ctrl.ld_ab)
    begin
      a_reg   <= rs_data;
      b_reg   <= rt_data;
      imm_reg <= {{(risc_pkg::XLEN-16){ir.i.imm16[15]}}, ir.i.imm16};
    end
    if (ctrl.ld_aluout)
      alu_out <= alu_result;
    if (ctrl.ld_lmd)
      lmd <= dmem_rdata;
  end

  assign alu_a   = ctrl.sel_a_pc ? npc : a_reg;
  assign alu_b   = ctrl.sel_b_imm ? imm_reg : b_reg;
  assign wr_idx  = ctrl.sel_dest_rt ? ir.i.rt[risc_pkg::REG_IDX_W-1:0]
                                    : ir.r.rd[risc_pkg::REG_IDX_W-1:0];
  assign wb_data = ctrl.sel_wb_mem ? lmd : alu_out;

  instr_mem instr_mem_i (
    .clk   (clk),
    .we    (imem_we),
    .waddr (imem_addr),
    .wdata (imem_wdata),
    .raddr (pc[risc_pkg::IMEM_ADDR_W+1:2]),
    .rdata (fetch_word)
  );

  reg_file reg_file_i (
    .clk     (clk),
    .rs_idx  (ir.r.rs[risc_pkg::REG_IDX_W-1:0]),
    .rt_idx  (ir.r.rt[risc_pkg::REG_IDX_W-1:0]),
    .wr_idx  (wr_idx),
    .wr_en   (ctrl.reg_write),
    .wr_data (wb_data),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  // ALU and condition check run side by side in EX
  alu alu_i (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .result(alu_result));

  branch_cond branch_cond_i (.value(a_reg), .cond(ctrl.cond), .taken(taken));

  data_mem data_mem_i (
    .clk   (clk),
    .we    (ctrl.mem_write),
    .addr  (alu_out[risc_pkg::DMEM_ADDR_W-1:0]),
    .wdata (b_reg),
    .rdata (dmem_rdata)
  );

  assign trace.wb_valid = ctrl.reg_write;
  assign trace.wb_reg   = wr_idx;
  assign trace.wb_data  = wb_data;
  assign trace.st_valid = ctrl.mem_write;
  assign trace.st_addr  = alu_out[risc_pkg::DMEM_ADDR_W-1:0];
  assign trace.st_data  = b_reg;

endmodule

//--- src/risc_core.sv
// Top level of the multicycle RISC core, joining the sequencer to the datapath
module risc_core (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start,
  input  logic                             imem_we,
  input  logic [risc_pkg::IMEM_ADDR_W-1:0] imem_addr,
  input  logic [risc_pkg::XLEN-1:0]        imem_wdata,
  output risc_pkg::trace_t                 trace,
  output logic                             halted
);

  risc_pkg::ctrl_t           ctrl;
  risc_pkg::instr_t          ir;
  logic [risc_pkg::XLEN-1:0] fetch_word;

  control_fsm control_fsm_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .ir         (ir),
    .fetch_word (fetch_word),
    .ctrl       (ctrl),
    .halted     (halted)
  );

  datapath datapath_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .ctrl       (ctrl),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .ir         (ir),
    .fetch_word (fetch_word),
    .trace      (trace)
  );

endmodule

//--- include/risc_tb_tasks.svh
// Encoders, reference model, trace capture and directed tests, included in the testbench top

typedef struct packed {
  logic        is_store;
  logic [9:0]  dest;      // wb_reg or st_addr
  logic [31:0] data;
  logic [15:0] cyc;       // Cycles after the start edge
} pulse_t;

logic [31:0] prog [$];
logic [31:0] ref_regs [16];
logic [31:0] ref_dmem [1024];
pulse_t      exp_q [$];
pulse_t      act_q [$];
int          exp_halt_cyc;

task automatic report_failure(string msg);
  $display("%s", msg);
  $display("*** FAILED ***");
  $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
  if (actual !== expected)
    report_failure($sformatf("Mismatch %s: expected 0x%08h, got 0x%08h", name, expected, actual));
endtask

function automatic logic [31:0] r_type_word(logic [5:0] fn, logic [3:0] rd, logic [3:0] rs,
                                            logic [3:0] rt);
  risc_pkg::instr_t w;
  w.word     = '0;
  w.r.opcode = risc_pkg::OP_R;
  w.r.rs     = {1'b0, rs};
  w.r.rt     = {1'b0, rt};
  w.r.rd     = {1'b0, rd};
  w.r.func   = fn;
  return w.word;
endfunction

// Immediate layout, also used for LD and ST
function automatic logic [31:0] imm_word(logic [5:0] op, logic [3:0] rt, logic [3:0] rs,
                                         logic [15:0] imm);
  risc_pkg::instr_t w;
  w.i.opcode = op;
  w.i.rs     = {1'b0, rs};
  w.i.rt     = {1'b0, rt};
  w.i.imm16  = imm;
  return w.word;
endfunction

function automatic logic [31:0] branch_word(logic [5:0] op, logic [3:0] rs, logic [15:0] off);
  return imm_word(op, 4'd0, rs, off);   // Word offset from PC+4
endfunction

// Operation index in the order ADD SUB AND OR XOR NOT SLA SLL SRA SRL
function automatic logic [31:0] alu_expect(int idx, logic [31:0] a, logic [31:0] b);
  case (idx)
    0:       return a + b;
    1:       return a - b;
    2:       return a & b;
    3:       return a | b;
    4:       return a ^ b;
    5:       return ~a;
    6, 7:    return a << b[0];
    8:       return $signed(a) >>> b[0];
    default: return a >> b[0];
  endcase
endfunction

task automatic predict_trace();
  risc_pkg::instr_t in;
  pulse_t           p;
  logic [31:0]      a;
  logic [31:0]      b;
  logic [31:0]      imm;
  logic [9:0]       addr;
  logic             take;
  logic             emit;
  int               pc;
  int               n;
  exp_q.delete();
  ref_regs[0] = 32'd0;                       // r0 always reads zero
  pc = 0;
  n  = 0;
  while (pc < prog.size() && prog[pc] != risc_pkg::HALT_WORD && n < MAX_MODEL_STEPS)
  begin
    in.word = prog[pc];
    a       = ref_regs[in.i.rs[3:0]];
    b       = ref_regs[in.i.rt[3:0]];
    imm     = {{16{in.i.imm16[15]}}, in.i.imm16};
    addr    = 10'(a + imm);
    pc      = pc + 1;
    p       = '0;
    p.cyc   = 16'(5 * n + 5);                // WB cycle of instruction n
    emit    = 1'b1;
    case (in.i.opcode[5:4])
      risc_pkg::CLASS_R:
      begin
        p.dest = 10'(in.r.rd[3:0]);
        p.data = alu_expect(int'(in.r.func) - 1, a, b);
      end
      risc_pkg::CLASS_I:
      begin
        p.dest = 10'(in.i.rt[3:0]);
        p.data = alu_expect((in.i.opcode == risc_pkg::OP_MOVE) ? 0 :
                            int'(in.i.opcode - risc_pkg::OP_ADDI), a, imm);
      end
      risc_pkg::CLASS_M:
      begin
        if (in.i.opcode == risc_pkg::OP_ST)
        begin
          p.is_store     = 1'b1;
          p.dest         = addr;
          p.data         = b;
          p.cyc          = 16'(5 * n + 4);   // Stores show in MEM
          ref_dmem[addr] = b;
        end
        else
        begin
          p.dest = 10'(in.i.rt[3:0]);
          p.data = ref_dmem[addr];
        end
      end
      default:
      begin
        emit = 1'b0;
        case (in.i.opcode)
          risc_pkg::OP_BMI: take = a[31];
          risc_pkg::OP_BPL: take = !a[31] && (a != 32'd0);
          risc_pkg::OP_BZ:  take = (a == 32'd0);
          default:          take = 1'b1;
        endcase
        if (take)
          pc = pc + int'($signed(imm));
      end
    endcase
    if (emit)
      exp_q.push_back(p);
    if (emit && !p.is_store && p.dest[3:0] != 4'd0)
      ref_regs[p.dest[3:0]] = p.data;
    n = n + 1;
  end
  exp_halt_cyc = 5 * n + 2;                  // HALT fetch IF, then halted
endtask

task automatic load_and_start();
  for (int k = 0; k < prog.size(); k++)
  begin
    @(posedge clk);
    #(DRIVE_DELAY);
    imem_we    = 1'b1;
    imem_addr  = 6'(k);
    imem_wdata = prog[k];
  end
  @(posedge clk);
  #(DRIVE_DELAY);
  imem_we = 1'b0;
  start   = 1'b1;
  @(posedge clk);                            // Start sampled here
  #(DRIVE_DELAY);
  start = 1'b0;
endtask

// Samples at the falling edge where trace is settled
task automatic collect_trace();
  pulse_t p;
  int     cyc;
  act_q.delete();
  cyc = 0;
  do
  begin
    @(negedge clk);
    cyc = cyc + 1;
    if (cyc > MAX_RUN_CYCLES)
      report_failure("The core never reached the halted state");
    if (trace.wb_valid || trace.st_valid)
    begin
      p.is_store = trace.st_valid;
      p.dest     = trace.st_valid ? trace.st_addr : 10'(trace.wb_reg);
      p.data     = trace.st_valid ? trace.st_data : trace.wb_data;
      p.cyc      = 16'(cyc);
      act_q.push_back(p);
    end
  end
  while (!halted);
  check_value("halt_cycle", 32'(exp_halt_cyc), 32'(cyc));
  repeat (3)
  begin
    @(negedge clk);
    check_value("trace_valid_after_halt", 32'd0, {30'd0, trace.wb_valid, trace.st_valid});
    check_value("halted", 32'd1, {31'd0, halted});
  end
endtask

task automatic compare_trace();
  check_value("pulse_count", 32'(exp_q.size()), 32'(act_q.size()));
  foreach (exp_q[k])
  begin
    check_value("st_valid", {31'd0, exp_q[k].is_store}, {31'd0, act_q[k].is_store});
    if (exp_q[k].is_store)
    begin
      check_value("st_addr", 32'(exp_q[k].dest), 32'(act_q[k].dest));
      check_value("st_data", exp_q[k].data, act_q[k].data);
    end
    else
    begin
      check_value("wb_reg", 32'(exp_q[k].dest), 32'(act_q[k].dest));
      check_value("wb_data", exp_q[k].data, act_q[k].data);
    end
    check_value("pulse_cycle", 32'(exp_q[k].cyc), 32'(act_q[k].cyc));   // 5-cycle spacing
  end
endtask

task automatic execute_program();
  prog.push_back(risc_pkg::HALT_WORD);
  load_and_start();
  predict_trace();
  collect_trace();
  compare_trace();
endtask

// Negative r1 tells SRA from SRL
task automatic r_type_ops();
  prog.delete();
  prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'd1, 4'd0, 16'($random(seed)) | 16'h8000));
  prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'd2, 4'd0, 16'($random(seed)) | 16'h0001));
  for (int f = 1; f <= 10; f++)
    prog.push_back(r_type_word(6'(f), 4'(f + 2), 4'd1, 4'd2));
  execute_program();
endtask

task automatic immediate_ops();
  prog.delete();
  prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'd1, 4'd0, 16'($random(seed)) | 16'h8000));
  for (int k = 0; k < 10; k++)
    prog.push_back(imm_word(6'(risc_pkg::OP_ADDI + k), 4'(k + 2), 4'd1,
                            16'($random(seed)) | 16'h0001));   // Shifts move by one
  prog.push_back(imm_word(risc_pkg::OP_MOVE, 4'd12, 4'd2, 16'd0));
  execute_program();
endtask

task automatic memory_path();
  prog.delete();
  prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'd5, 4'd0, 16'($random(seed)) & 16'h01F0));
  for (int k = 0; k < 4; k++)
    prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'(k + 1), 4'd0, 16'($random(seed))));
  for (int k = 0; k < 4; k++)
    prog.push_back(imm_word(risc_pkg::OP_ST, 4'(k + 1), 4'd5, 16'(3 * k + 1)));
  for (int k = 0; k < 4; k++)
    prog.push_back(imm_word(risc_pkg::OP_LD, 4'(k + 6), 4'd5, 16'(3 * k + 1)));
  execute_program();
endtask

// Every branch jumps over one ADDI when taken
task automatic branch_kinds();
  prog.delete();
  prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'd1, 4'd0, 16'($random(seed)) | 16'h8000));
  prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'd2, 4'd0,
                          (16'($random(seed)) & 16'h7FFF) | 16'h0001));
  prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'd3, 4'd0, 16'd0));
  for (int kind = 0; kind < 4; kind++)
  begin
    for (int src = 1; src <= 3; src++)
    begin
      prog.push_back(branch_word(6'(risc_pkg::OP_BR + kind), 4'(src), 16'd1));
      prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'(3 + 3 * kind + src), 4'd0,
                              16'(4 * kind + src)));
    end
  end
  execute_program();
endtask

// Second program is shorter, so stale words past its HALT must never run
task automatic halt_and_rerun();
  prog.delete();
  for (int k = 0; k < 5; k++)
    prog.push_back(imm_word(risc_pkg::OP_ADDI, 4'(k + 1), 4'd0, 16'($random(seed))));
  execute_program();
  prog.delete();
  prog.push_back(imm_word(risc_pkg::OP_SUBI, 4'd6, 4'd1, 16'($random(seed))));
  prog.push_back(r_type_word(risc_pkg::FN_XOR, 4'd7, 4'd2, 4'd3));
  execute_program();
endtask

//--- tb/risc_tb.sv
// Testbench top for the RISC core: clock, reset, watchdog, DUT and the directed test sequence
module risc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD       = 100;
  localparam int DRIVE_DELAY      = 5;
  localparam int NUM_TESTS        = 5;
  localparam int INSTR_PER_TEST   = 20;
  localparam int CYCLES_PER_INSTR = 5;
  localparam int MARGIN_NS        = 20000;
  localparam int WATCHDOG_NS      = NUM_TESTS * INSTR_PER_TEST * CYCLES_PER_INSTR * CLK_PERIOD
                                    + MARGIN_NS;
  localparam int MAX_RUN_CYCLES   = 64 * CYCLES_PER_INSTR + 10;   // Whole IMEM plus slack
  localparam int MAX_MODEL_STEPS  = 64;

  logic                                   clk;
  logic                                   reset;
  logic                                   start;
  logic                                   imem_we;
  logic [risc_pkg::IMEM_ADDR_W-1:0]       imem_addr;
  logic [risc_pkg::XLEN-1:0]              imem_wdata;
  risc_pkg::trace_t                       trace;
  logic                                   halted;
  int                                     seed;

  risc_core risc_core_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .trace      (trace),
    .halted     (halted)
  );

  `include "risc_tb_tasks.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial
  begin
    #(WATCHDOG_NS);
    report_failure("Watchdog expired before the tests finished");
  end

  initial
  begin
    clk        = 1'b0;
    reset      = 1'b0;
    start      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    seed       = 33111;
    repeat (2) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b1;
    check_value("halted", 32'd1, {31'd0, halted});   // Core idles after reset
    r_type_ops();
    immediate_ops();
    memory_path();
    branch_kinds();
    halt_and_rerun();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
src/risc_pkg.sv
src/alu.sv
src/branch_cond.sv
src/reg_file.sv
src/instr_mem.sv
src/data_mem.sv
src/control_fsm.sv
src/datapath.sv
src/risc_core.sv
tb/risc_tb.sv

//--- Makefile
# Verilator lint and simulation of the RISC core testbench

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= risc_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
